//--- usb_bridge_pkg.sv
package usb_bridge_pkg;

    // one byte on the bus or in a FIFO.
    typedef logic [7:0] byte_t;

    // one transfer on usb_miosi in 4-bit mode.
    typedef logic [3:0] nibble_t;

    // bus master states.
    typedef enum logic [1:0] {
        try_rx,
        try_tx,
        command,
        data
    } ft_state_e;

    // bit index into the one-hot bus clock phase ring.
    typedef enum logic [1:0] {
        pre_rising,
        rising,
        pre_falling,
        falling
    } ft_phase_e;

    // command bytes, sent high nibble first.
    typedef enum logic [7:0] {
        cmd_write = 8'h00,
        cmd_read  = 8'h04
    } ft_command_e;

    // one received byte, valid for a single cycle.
    typedef struct packed {
        logic  valid;
        byte_t data;
    } ft_rx_beat_t;

endpackage

//--- usb_byte_fifo.sv
`timescale 1ns/100ps

module usb_byte_fifo #(
    parameter int FIFO_ADDR_BITS = 4
) (
    input  logic                  sys,
    input  logic                  rst_n,

    input  logic                  enable,
    input  logic                  flush,

    input  logic                  push,
    input  usb_bridge_pkg::byte_t push_data,
    output logic                  full,

    input  logic                  pop,
    output usb_bridge_pkg::byte_t pop_data,
    output logic                  empty
);

    localparam int DEPTH = 1 << FIFO_ADDR_BITS;

    usb_bridge_pkg::byte_t mem [DEPTH];

    logic [FIFO_ADDR_BITS-1:0] wr_ptr;
    logic [FIFO_ADDR_BITS-1:0] rd_ptr;
    logic [FIFO_ADDR_BITS:0]   count;

    logic do_push;
    logic do_pop;

    // count never exceeds DEPTH, so its top bit alone marks full.
    assign full  = count[FIFO_ADDR_BITS];
    assign empty = count == '0;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // first word fall through, the head is always on the read port.
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge sys) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge sys) begin
        if (!rst_n || flush || !enable) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- usb_escape_filter.sv
`timescale 1ns/100ps

module usb_escape_filter #(
    parameter usb_bridge_pkg::byte_t ESCAPE_CHARACTER = 8'h1B
) (
    input  logic                        sys,
    input  logic                        rst_n,
    input  logic                        enable,

    input  usb_bridge_pkg::ft_rx_beat_t rx_beat,

    input  logic                        fifo_full,
    output logic                        fifo_write,
    output usb_bridge_pkg::byte_t       fifo_data,

    output logic                        rx_ready,

    input  logic                        escape_ack,
    output logic                        escape_valid,
    output usb_bridge_pkg::byte_t       escape_code
);

    // last byte was an escape character still waiting for its partner.
    logic escape_active;
    logic is_escape;

    assign is_escape = rx_beat.data == ESCAPE_CHARACTER;

    // a pending code blocks reads until software has seen it.
    assign rx_ready = !fifo_full && !escape_valid;

    always_ff @(posedge sys) begin
        if (!rst_n || !enable) begin
            escape_active <= 1'b0;
            escape_valid  <= 1'b0;
            fifo_write    <= 1'b0;
        end else begin
            fifo_write <= 1'b0;

            if (escape_ack) begin
                escape_valid <= 1'b0;
            end

            if (rx_beat.valid) begin
                if (!escape_active) begin
                    fifo_write    <= !is_escape;
                    escape_active <= is_escape;
                end else begin
                    // doubled escape gives one literal escape byte.
                    escape_active <= 1'b0;
                    fifo_write    <= is_escape;
                    if (!is_escape) begin
                        escape_valid <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge sys) begin
        fifo_data <= rx_beat.data;
        if (rx_beat.valid && escape_active && !is_escape) begin
            escape_code <= rx_beat.data;
        end
    end

endmodule

//--- usb_ft1248_ctrl.sv
`timescale 1ns/100ps

module usb_ft1248_ctrl (
    input  logic                          sys,
    input  logic                          rst_n,
    input  logic                          enable,

    output logic                          usb_clk,
    output logic                          usb_cs,
    input  logic                          usb_miso,
    inout  wire usb_bridge_pkg::nibble_t  usb_miosi,

    input  logic                          rx_ready,
    output usb_bridge_pkg::ft_rx_beat_t   rx_beat,

    input  logic                          tx_empty,
    input  usb_bridge_pkg::byte_t         tx_data,
    output logic                          tx_pop
);

    usb_bridge_pkg::ft_state_e   state;
    usb_bridge_pkg::ft_command_e command_byte;

    // one-hot ring, one bit per sys cycle of a bus clock period.
    logic [3:0] clock_phase;
    logic [1:0] nibble_counter;
    logic       is_write;

    logic                    miso_in;
    usb_bridge_pkg::nibble_t miosi_in;
    usb_bridge_pkg::nibble_t miosi_out;
    logic                    miosi_oe;

    logic                    clk_next;
    logic                    cs_next;
    usb_bridge_pkg::nibble_t miosi_next;
    logic                    oe_next;

    usb_bridge_pkg::byte_t tx_buffer;
    usb_bridge_pkg::byte_t rx_shift;
    logic                  rx_valid;

    logic stop_transfer;
    logic in_try;

    assign in_try = state == usb_bridge_pkg::try_rx || state == usb_bridge_pkg::try_tx;

    // not-ready from the chip ends either direction.
    assign stop_transfer = miso_in || (is_write ? tx_empty : !rx_ready);

    assign rx_beat = '{valid: rx_valid, data: rx_shift};

    assign usb_miosi = miosi_oe ? miosi_out : 'z;

    always_ff @(posedge sys) begin
        if (!rst_n || in_try) begin
            clock_phase <= '0;
            clock_phase[usb_bridge_pkg::pre_rising] <= 1'b1;
        end else begin
            clock_phase <= {clock_phase[2:0], clock_phase[3]};
        end
    end

    always_comb begin
        if (is_write) begin
            command_byte = usb_bridge_pkg::cmd_write;
        end else begin
            command_byte = usb_bridge_pkg::cmd_read;
        end
    end

    always_comb begin
        clk_next   = 1'b0;
        cs_next    = 1'b1;
        miosi_next = 4'hF;
        oe_next    = 1'b0;

        case (state)
            usb_bridge_pkg::command: begin
                clk_next = clock_phase[usb_bridge_pkg::pre_falling] ||
                           clock_phase[usb_bridge_pkg::falling];
                cs_next  = 1'b0;
                miosi_next = nibble_counter[0] ? command_byte[3:0] : command_byte[7:4];
                // turnaround nibble leaves the bus released.
                oe_next  = nibble_counter < 2'd2;
            end

            usb_bridge_pkg::data: begin
                clk_next = clock_phase[usb_bridge_pkg::pre_falling] ||
                           clock_phase[usb_bridge_pkg::falling];
                cs_next  = 1'b0;
                miosi_next = nibble_counter[0] ? tx_buffer[7:4] : tx_buffer[3:0];
                oe_next  = is_write;
            end

            default: begin
            end
        endcase
    end

    // bus pins go through one register stage each way.
    always_ff @(posedge sys) begin
        if (!rst_n) begin
            usb_clk  <= 1'b0;
            usb_cs   <= 1'b1;
            miosi_oe <= 1'b0;
        end else begin
            usb_clk  <= clk_next;
            usb_cs   <= cs_next;
            miosi_oe <= oe_next;
        end
    end

    always_ff @(posedge sys) begin
        miosi_out <= miosi_next;
        miosi_in  <= usb_miosi;
        miso_in   <= usb_miso;
        tx_buffer <= tx_data;
        // low nibble arrives first and ends up in the bottom half.
        if (state == usb_bridge_pkg::data && clock_phase[usb_bridge_pkg::rising]) begin
            rx_shift <= {miosi_in, rx_shift[7:4]};
        end
    end

    always_ff @(posedge sys) begin
        if (!rst_n || !enable) begin
            state          <= usb_bridge_pkg::try_rx;
            nibble_counter <= '0;
            is_write       <= 1'b0;
            rx_valid       <= 1'b0;
            tx_pop         <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            tx_pop   <= 1'b0;

            if (clock_phase[usb_bridge_pkg::rising]) begin
                nibble_counter <= nibble_counter + 1'b1;
            end

            case (state)
                usb_bridge_pkg::try_rx: begin
                    if (rx_ready) begin
                        state          <= usb_bridge_pkg::command;
                        is_write       <= 1'b0;
                        nibble_counter <= 2'd3;
                    end else begin
                        state <= usb_bridge_pkg::try_tx;
                    end
                end

                usb_bridge_pkg::try_tx: begin
                    if (!tx_empty) begin
                        state          <= usb_bridge_pkg::command;
                        is_write       <= 1'b1;
                        nibble_counter <= 2'd3;
                    end else begin
                        state <= usb_bridge_pkg::try_rx;
                    end
                end

                usb_bridge_pkg::command: begin
                    if (clock_phase[usb_bridge_pkg::rising] && nibble_counter == 2'd2) begin
                        if (miso_in) begin
                            state <= is_write ? usb_bridge_pkg::try_rx : usb_bridge_pkg::try_tx;
                        end else begin
                            state          <= usb_bridge_pkg::data;
                            nibble_counter <= 2'd0;
                        end
                    end
                end

                usb_bridge_pkg::data: begin
                    // the high nibble has gone out, so release the head byte.
                    if (clock_phase[usb_bridge_pkg::falling] && nibble_counter[0]) begin
                        tx_pop <= is_write;
                    end
                    if (clock_phase[usb_bridge_pkg::rising]) begin
                        if (nibble_counter[0]) begin
                            rx_valid <= !is_write;
                        end
                        if (stop_transfer) begin
                            state <= is_write ? usb_bridge_pkg::try_rx : usb_bridge_pkg::try_tx;
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- usb_ft1248.sv
`timescale 1ns/100ps

module usb_ft1248 #(
    parameter int                    FIFO_ADDR_BITS   = 4,
    parameter usb_bridge_pkg::byte_t ESCAPE_CHARACTER = 8'h1B
) (
    input  logic                         sys,
    input  logic                         rst_n,

    input  logic                         usb_enabled,

    output logic                         usb_clk,
    output logic                         usb_cs,
    input  logic                         usb_miso,
    inout  wire usb_bridge_pkg::nibble_t usb_miosi,

    input  logic                         rx_flush,
    output logic                         rx_empty,
    input  logic                         rx_read,
    output usb_bridge_pkg::byte_t        rx_rdata,

    input  logic                         tx_flush,
    output logic                         tx_full,
    input  logic                         tx_write,
    input  usb_bridge_pkg::byte_t        tx_wdata,

    output logic                         rx_escape_valid,
    input  logic                         rx_escape_ack,
    output usb_bridge_pkg::byte_t        rx_escape
);

    usb_bridge_pkg::ft_rx_beat_t rx_beat;

    logic                  rx_full;
    logic                  rx_write;
    usb_bridge_pkg::byte_t rx_wdata;
    logic                  rx_ready;

    logic                  tx_empty;
    logic                  tx_pop;
    usb_bridge_pkg::byte_t tx_rdata;

    usb_byte_fifo #(
        .FIFO_ADDR_BITS(FIFO_ADDR_BITS)
    ) rx_fifo (
        .sys      (sys),
        .rst_n    (rst_n),
        .enable   (usb_enabled),
        .flush    (rx_flush),
        .push     (rx_write),
        .push_data(rx_wdata),
        .full     (rx_full),
        .pop      (rx_read),
        .pop_data (rx_rdata),
        .empty    (rx_empty)
    );

    usb_byte_fifo #(
        .FIFO_ADDR_BITS(FIFO_ADDR_BITS)
    ) tx_fifo (
        .sys      (sys),
        .rst_n    (rst_n),
        .enable   (usb_enabled),
        .flush    (tx_flush),
        .push     (tx_write),
        .push_data(tx_wdata),
        .full     (tx_full),
        .pop      (tx_pop),
        .pop_data (tx_rdata),
        .empty    (tx_empty)
    );

    usb_escape_filter #(
        .ESCAPE_CHARACTER(ESCAPE_CHARACTER)
    ) escape_filter (
        .sys         (sys),
        .rst_n       (rst_n),
        .enable      (usb_enabled),
        .rx_beat     (rx_beat),
        .fifo_full   (rx_full),
        .fifo_write  (rx_write),
        .fifo_data   (rx_wdata),
        .rx_ready    (rx_ready),
        .escape_ack  (rx_escape_ack),
        .escape_valid(rx_escape_valid),
        .escape_code (rx_escape)
    );

    usb_ft1248_ctrl ctrl (
        .sys      (sys),
        .rst_n    (rst_n),
        .enable   (usb_enabled),
        .usb_clk  (usb_clk),
        .usb_cs   (usb_cs),
        .usb_miso (usb_miso),
        .usb_miosi(usb_miosi),
        .rx_ready (rx_ready),
        .rx_beat  (rx_beat),
        .tx_empty (tx_empty),
        .tx_data  (tx_rdata),
        .tx_pop   (tx_pop)
    );

endmodule

//--- tb_ft1248_device.sv
`timescale 1ns/100ps

module tb_ft1248_device (
    input  logic       sys,
    input  logic       usb_clk,
    input  logic       usb_cs,
    output logic       usb_miso,
    inout  wire  [3:0] usb_miosi,
    input  logic       not_ready
);

    logic [7:0] send_q[$];
    logic [7:0] capture_q[$];

    logic       clk_seen = 1'b0;
    int         high_count = 0;
    logic [3:0] cmd_high = 4'h0;
    logic [3:0] low_nibble = 4'h0;
    logic       reading = 1'b0;
    logic       drive = 1'b0;
    logic [3:0] drive_value = 4'h0;

    assign usb_miosi = drive ? drive_value : 'z;

    task automatic queue_byte(input logic [7:0] value);
        send_q.push_back(value);
    endtask

    function automatic int pending_count();
        return send_q.size();
    endfunction

    function automatic int captured_count();
        return capture_q.size();
    endfunction

    task automatic take_captured(output logic [7:0] value);
        value = capture_q.pop_front();
    endtask

    // bus pins are looked at mid cycle, away from the controller's edges.
    always @(negedge sys) begin
        if (usb_cs) begin
            high_count = 0;
            reading    = 1'b0;
            drive      = 1'b0;
        end else if (usb_clk && !clk_seen) begin
            high_count = high_count + 1;
            if (high_count == 1) begin
                cmd_high = usb_miosi;
            end else if (high_count == 2) begin
                reading = {cmd_high, usb_miosi} == 8'h04;
            end else if (high_count >= 4) begin
                // data nibbles, low nibble first.
                if (reading) begin
                    if (send_q.size() != 0) begin
                        drive = 1'b1;
                        if ((high_count - 4) % 2 == 0) begin
                            drive_value = send_q[0][3:0];
                        end else begin
                            drive_value = send_q[0][7:4];
                            void'(send_q.pop_front());
                        end
                    end
                end else if ((high_count - 4) % 2 == 0) begin
                    low_nibble = usb_miosi;
                end else begin
                    capture_q.push_back({usb_miosi, low_nibble});
                end
            end
        end
        clk_seen = usb_clk;
        // high means not ready, also when a read has nothing left to send.
        usb_miso = not_ready || (reading && send_q.size() == 0);
    end

endmodule

//--- tb_usb_ft1248.sv
`timescale 1ns/100ps

module tb_usb_ft1248;

    localparam int TIMEOUT = 20000;

    logic       sys;
    logic       rst_n;
    logic       usb_enabled;
    logic       usb_clk;
    logic       usb_cs;
    logic       usb_miso;
    wire  [3:0] usb_miosi;
    logic       rx_flush;
    logic       rx_empty;
    logic       rx_read;
    logic [7:0] rx_rdata;
    logic       tx_flush;
    logic       tx_full;
    logic       tx_write;
    logic [7:0] tx_wdata;
    logic       rx_escape_valid;
    logic       rx_escape_ack;
    logic [7:0] rx_escape;
    logic       not_ready;

    logic [15:0] lfsr_state = 16'd24;
    string       test_name;
    int          test_errors;
    int          passed_tests = 0;
    int          failed_tests = 0;
    logic [7:0]  expected_q[$];

    usb_ft1248 dut (.*);

    tb_ft1248_device device (
        .sys      (sys),
        .usb_clk  (usb_clk),
        .usb_cs   (usb_cs),
        .usb_miso (usb_miso),
        .usb_miosi(usb_miosi),
        .not_ready(not_ready)
    );

    initial begin
        sys = 1'b0;
        forever #50 sys = ~sys;
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11, stepped once per bit.
    function automatic logic [7:0] random_byte();
        logic [7:0] value;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            value[i] = lfsr_state[0];
        end
        return value;
    endfunction

    task automatic check_value(input string what, input logic [7:0] expected,
                               input logic [7:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s %s: expected %02h actual %02h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_problem(input string text);
        $display("%s: %s", test_name, text);
        test_errors++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            passed_tests++;
            $display("test %s passed", test_name);
        end else begin
            failed_tests++;
            $display("test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic read_rx_byte(output logic [7:0] value);
        int waited;
        waited = 0;
        while (rx_empty && waited < TIMEOUT) begin
            @(negedge sys);
            waited++;
        end
        if (rx_empty) begin
            report_problem("timed out waiting for receive data");
        end
        value = rx_rdata;
        rx_read = 1'b1;
        @(negedge sys);
        rx_read = 1'b0;
    endtask

    task automatic write_tx_byte(input logic [7:0] value);
        int waited;
        waited = 0;
        while (tx_full && waited < TIMEOUT) begin
            @(negedge sys);
            waited++;
        end
        if (tx_full) begin
            report_problem("timed out waiting for room in the transmit FIFO");
        end
        tx_wdata = value;
        tx_write = 1'b1;
        @(negedge sys);
        tx_write = 1'b0;
    endtask

    task automatic wait_captured(input int count);
        int waited;
        waited = 0;
        while (device.captured_count() < count && waited < TIMEOUT) begin
            @(negedge sys);
            waited++;
        end
        if (device.captured_count() < count) begin
            report_problem("timed out waiting for bytes at the device");
        end
    endtask

    task automatic wait_pending(input int count);
        int waited;
        waited = 0;
        while (device.pending_count() > count && waited < TIMEOUT) begin
            @(negedge sys);
            waited++;
        end
        if (device.pending_count() > count) begin
            report_problem("timed out waiting for the device to send");
        end
    endtask

    task automatic wait_escape();
        int waited;
        waited = 0;
        while (!rx_escape_valid && waited < TIMEOUT) begin
            @(negedge sys);
            waited++;
        end
        if (!rx_escape_valid) begin
            report_problem("timed out waiting for an escape code");
        end
    endtask

    task automatic pulse_ack();
        rx_escape_ack = 1'b1;
        @(negedge sys);
        rx_escape_ack = 1'b0;
        @(negedge sys);
    endtask

    // random byte that is never the escape character.
    task automatic plain_byte(output logic [7:0] value);
        value = random_byte();
        while (value == 8'h1B) begin
            value = random_byte();
        end
    endtask

    task automatic queue_plain_bytes(input int count);
        logic [7:0] value;
        for (int i = 0; i < count; i++) begin
            plain_byte(value);
            expected_q.push_back(value);
            device.queue_byte(value);
        end
    endtask

    task automatic read_expected(input int count);
        logic [7:0] value;
        for (int i = 0; i < count; i++) begin
            read_rx_byte(value);
            check_value("rx byte", expected_q.pop_front(), value);
        end
    endtask

    task automatic send_and_capture(input int count);
        logic [7:0] value;
        for (int i = 0; i < count; i++) begin
            value = random_byte();
            expected_q.push_back(value);
            write_tx_byte(value);
        end
        wait_captured(count);
        while (device.captured_count() > 0) begin
            device.take_captured(value);
            check_value("captured byte", expected_q.pop_front(), value);
        end
    endtask

    task automatic idle_after_reset();
        int cs_high;
        start_test("idle");
        cs_high = 0;
        for (int i = 0; i < 400; i++) begin
            @(negedge sys);
            cs_high += usb_cs;
            check_value("rx_empty", 8'd1, {7'd0, rx_empty});
            check_value("tx_full", 8'd0, {7'd0, tx_full});
            check_value("rx_escape_valid", 8'd0, {7'd0, rx_escape_valid});
        end
        if (cs_high == 0) begin
            report_problem("usb_cs never went high between tries");
        end
        finish_test();
    endtask

    task automatic transmit_random_bytes();
        start_test("transmit");
        send_and_capture(12);
        finish_test();
    endtask

    task automatic receive_random_bytes();
        start_test("receive");
        queue_plain_bytes(12);
        read_expected(12);
        finish_test();
    endtask

    task automatic escape_sequence();
        logic [7:0] value;
        start_test("escape");
        device.queue_byte(8'h41);
        device.queue_byte(8'h1B);
        device.queue_byte(8'h7E);
        device.queue_byte(8'h1B);
        device.queue_byte(8'h1B);
        device.queue_byte(8'h42);
        read_rx_byte(value);
        check_value("first byte", 8'h41, value);
        wait_escape();
        check_value("escape code", 8'h7E, rx_escape);
        repeat (400) @(negedge sys);
        check_value("rx_empty while held", 8'd1, {7'd0, rx_empty});
        check_value("escape still held", 8'd1, {7'd0, rx_escape_valid});
        pulse_ack();
        check_value("escape after ack", 8'd0, {7'd0, rx_escape_valid});
        read_rx_byte(value);
        check_value("literal escape", 8'h1B, value);
        read_rx_byte(value);
        check_value("last byte", 8'h42, value);
        finish_test();
    endtask

    task automatic receive_back_pressure();
        logic [7:0] value;
        start_test("back_pressure");
        queue_plain_bytes(24);
        wait_pending(8);
        for (int i = 0; i < 500; i++) begin
            @(negedge sys);
            check_value("rx_empty while full", 8'd0, {7'd0, rx_empty});
        end
        check_value("bytes left in device", 8'd8, 8'(device.pending_count()));
        read_expected(24);
        not_ready = 1'b1;
        queue_plain_bytes(4);
        for (int i = 0; i < 4; i++) begin
            write_tx_byte(8'hA0 + 8'(i));
        end
        repeat (2000) @(negedge sys);
        check_value("rx_empty when not ready", 8'd1, {7'd0, rx_empty});
        check_value("captured when not ready", 8'd0, 8'(device.captured_count()));
        check_value("pending when not ready", 8'd4, 8'(device.pending_count()));
        not_ready = 1'b0;
        read_expected(4);
        wait_captured(4);
        for (int i = 0; i < 4; i++) begin
            device.take_captured(value);
            check_value("resumed tx byte", 8'hA0 + 8'(i), value);
        end
        finish_test();
    endtask

    task automatic flush_and_disable();
        logic [7:0] value;
        start_test("flush_disable");
        for (int i = 0; i < 3; i++) begin
            plain_byte(value);
            device.queue_byte(value);
        end
        wait_pending(0);
        repeat (100) @(negedge sys);
        check_value("rx_empty before flush", 8'd0, {7'd0, rx_empty});
        rx_flush = 1'b1;
        @(negedge sys);
        rx_flush = 1'b0;
        @(negedge sys);
        check_value("rx_empty after flush", 8'd1, {7'd0, rx_empty});
        not_ready = 1'b1;
        write_tx_byte(8'h11);
        write_tx_byte(8'h22);
        tx_flush = 1'b1;
        @(negedge sys);
        tx_flush = 1'b0;
        not_ready = 1'b0;
        repeat (1000) @(negedge sys);
        check_value("captured after flush", 8'd0, 8'(device.captured_count()));
        device.queue_byte(8'h1B);
        device.queue_byte(8'h55);
        wait_escape();
        usb_enabled = 1'b0;
        repeat (2) @(negedge sys);
        for (int i = 0; i < 100; i++) begin
            @(negedge sys);
            check_value("usb_cs disabled", 8'd1, {7'd0, usb_cs});
            check_value("usb_clk disabled", 8'd0, {7'd0, usb_clk});
            check_value("rx_empty disabled", 8'd1, {7'd0, rx_empty});
            check_value("escape disabled", 8'd0, {7'd0, rx_escape_valid});
        end
        usb_enabled = 1'b1;
        finish_test();
    endtask

    initial begin
        rst_n         = 1'b0;
        usb_enabled   = 1'b1;
        rx_flush      = 1'b0;
        rx_read       = 1'b0;
        tx_flush      = 1'b0;
        tx_write      = 1'b0;
        tx_wdata      = 8'h00;
        rx_escape_ack = 1'b0;
        not_ready     = 1'b0;
        repeat (16) @(negedge sys);
        rst_n = 1'b1;

        idle_after_reset();
        transmit_random_bytes();
        receive_random_bytes();
        escape_sequence();
        receive_back_pressure();
        flush_and_disable();

        $display("tests passed %0d failed %0d", passed_tests, failed_tests);
        if (failed_tests == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- usb_ft1248.f
usb_bridge_pkg.sv
usb_byte_fifo.sv
usb_escape_filter.sv
usb_ft1248_ctrl.sv
usb_ft1248.sv
tb_ft1248_device.sv
tb_usb_ft1248.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_usb_ft1248 -f usb_ft1248.f -o sim_tb_usb_ft1248

output=$(./obj_dir/sim_tb_usb_ft1248)
echo "$output"

if echo "$output" | grep -q "RESULT: PASS"; then
    exit 0
else
    exit 1
fi
